/* verif/memInit.hex */
// ram image, one hex byte per value, 16 bytes per line
// line n holds byte addresses 16*n to 16*n+15, everything above is zero
13 05 00 00 93 02 40 06 b7 31 00 00 23 a0 51 00
03 a3 01 00 63 0e 03 00 13 03 f3 ff 6f f0 9f ff
5a c3 17 e8 94 2b 7d 06 f1 3e a9 50 c4 88 1f 6b
27 d2 9c 41 b0 0e 73 fa 65 18 ce 32 8d 4f e3 a7
11 b6 5c 29 f8 03 9a 74 df 61 2c 87 40 bd 16 e5
33 7a c1 0f 9e 52 d4 68 a5 1c 86 fb 2e 49 b3 d7
6e 04 f5 91 3b c8 57 22 8a ef 10 6d d9 35 a2 7c
e0 4b 19 b8 72 26 cf 95 0d 63 fe 81 54 ba 28 c6
97 3d 6a e4 01 bf 48 5d f3 2a 8f 76 c0 14 e9 53
b4 79 25 dc 0a 6f 93 47 1e a8 d1 3c 85 f6 62 0b
4d e7 98 30 cb 15 7e a3 59 f2 06 8c 37 da 43 b1
f9 24 6c 8e 13 d5 a0 5f 2b c7 71 09 ec 46 be 92
08 5b d3 a6 47 fc 31 7f 96 02 c9 6b 1a e2 84 3f
c5 70 2d 9b e6 4a b7 18 73 de 05 a1 58 8b f4 26
39 af 12 c2 87 64 fd 4e b9 20 5e d0 0c 9f 75 ea
a4 17 b5 6a dd 0f 83 c3 3a 97 e1 28 bc 51 06 f7
62 cd 44 f0 1b 8e 29 b2 d6 75 4c 03 e8 ad 90 1d

/* sim.f */
source/memPkg.sv
source/byteRam.sv
source/memCtrl.sv
source/memSubsystem.sv
verif/memCtrlProperties.sv
verif/memSubsystemTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = memSubsystemTb
FILELIST  = sim.f

BUILD   = obj_dir
SIM     = $(BUILD)/V$(TOP)
LOG     = sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* verif/memSubsystemTb.sv */
`default_nettype none

module memSubsystemTb
    import memPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 200;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic rdy = 1'b1;
    logic ioBufferFull = 1'b0;
    logic fetchEn;
    addr_t fetchAddr;
    logic fetchDone;
    word_t fetchInst;
    logic dataEn;
    dataReq_t dataReq;
    logic dataDone;
    word_t dataRdata;

    // expected ram contents
    byte_t shadow [0:RAM_DEPTH-1];

    logic [31:0] lfsr = 32'h66cb_77d3;
    int valueErrors = 0;
    int otherErrors = 0;
    int propErrors = 0;
    time fetchDoneAt;
    time dataDoneAt;

    // stall burst generator
    logic stallOn = 1'b0;
    logic stallNext = 1'b0;
    logic burstOnIo = 1'b0;
    int burstLeft = 0;

    memSubsystem dut0 (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataEn       (dataEn),
        .dataReq      (dataReq),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata)
    );

    always #4 clk = ~clk;

    // galois lfsr with one step per bit taken
    function automatic logic [31:0] lfsrBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    // low byte window stays inside the preloaded image
    function automatic addr_t imageAddr();
        logic [31:0] high;
        logic [31:0] low;
        high = lfsrBits(22);
        low = lfsrBits(8);
        return {high[21:0], 2'b00, low[7:0]};
    endfunction

    function automatic len_t pickLen();
        logic [31:0] pick;
        pick = lfsrBits(2);
        if (pick[1:0] == 2'd0) begin
            return 3'd1;
        end else if (pick[1:0] == 2'd1) begin
            return 3'd2;
        end
        return 3'd4;
    endfunction

    // little-endian bytes from the shadow with zeros above len
    function automatic word_t expectedBytes(input addr_t addr, input len_t len);
        word_t value;
        addr_t byteAddr;
        value = '0;
        for (int k = 0; k < int'(len); k++) begin
            byteAddr = addr + addr_t'(k);
            value[8*k +: 8] = shadow[byteAddr[RAM_ADDR_W-1:0]];
        end
        return value;
    endfunction

    function automatic void updateShadow(input addr_t addr, input len_t len, input word_t data);
        addr_t byteAddr;
        for (int k = 0; k < int'(len); k++) begin
            byteAddr = addr + addr_t'(k);
            shadow[byteAddr[RAM_ADDR_W-1:0]] = data[8*k +: 8];
        end
    endfunction

    function automatic void checkWord(input string name, input word_t actual,
                                      input word_t expected);
        assert (actual == expected) else begin
            valueErrors++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endfunction

    task automatic fetchWord(input addr_t addr);
        int waited;
        fetchAddr = addr;
        fetchEn = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!fetchDone && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (fetchDone) begin
            fetchDoneAt = $time;
            checkWord("fetchInst", fetchInst, expectedBytes(addr, FETCH_LEN));
        end else begin
            otherErrors++;
            $display("timeout: fetch from %h never completed", addr);
        end
        @(posedge clk);
        #1;
        fetchEn = 1'b0;
    endtask

    task automatic accessData(input logic isStore, input len_t len, input addr_t addr,
                              input word_t data);
        int waited;
        dataReq.write = isStore;
        dataReq.len = len;
        dataReq.addr = addr;
        dataReq.storeData = data;
        dataEn = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!dataDone && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!dataDone) begin
            otherErrors++;
            $display("timeout: data access at %h never completed", addr);
        end else if (isStore) begin
            dataDoneAt = $time;
            updateShadow(addr, len, data);
        end else begin
            dataDoneAt = $time;
            checkWord("dataRdata", dataRdata, expectedBytes(addr, len));
        end
        @(posedge clk);
        #1;
        dataEn = 1'b0;
    endtask

    task automatic storeThenLoad();
        addr_t addr;
        len_t len;
        word_t data;
        addr = imageAddr();
        len = pickLen();
        data = lfsrBits(32);
        accessData(1'b1, len, addr, data);
        accessData(1'b0, 3'd1, addr, '0);
        accessData(1'b0, 3'd2, addr, '0);
        accessData(1'b0, 3'd4, addr, '0);
        // bytes on either side stay untouched
        accessData(1'b0, 3'd4, addr - 32'd4, '0);
        accessData(1'b0, 3'd4, addr + addr_t'(len), '0);
    endtask

    task automatic raceDataFetch();
        addr_t fetchTarget;
        addr_t dataTarget;
        len_t len;
        logic [31:0] pick;
        word_t data;
        fetchTarget = imageAddr();
        dataTarget = imageAddr();
        len = pickLen();
        pick = lfsrBits(1);
        data = lfsrBits(32);
        fetchDoneAt = '0;
        dataDoneAt = '0;
        fork
            fetchWord(fetchTarget);
            accessData(pick[0], len, dataTarget, data);
        join
        assert (dataDoneAt != '0 && dataDoneAt < fetchDoneAt) else begin
            otherErrors++;
            $display("data request did not finish before the fetch at %0t", $time);
        end
    endtask

    // decided at negedge and driven after the next rising edge
    always begin
        @(negedge clk);
        stallNext = 1'b0;
        if (stallOn) begin
            if (burstLeft == 0 && lfsrBits(2) == 32'd0) begin
                burstLeft = int'(lfsrBits(2)) + 1;
                burstOnIo = lfsrBits(1) != 32'd0;
            end
            if (burstLeft > 0) begin
                stallNext = 1'b1;
                burstLeft--;
            end
        end
        @(posedge clk);
        #1;
        rdy = !(stallNext && !burstOnIo);
        ioBufferFull = stallNext && burstOnIo;
    end

    initial begin
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataReq = '0;
        for (int i = 0; i < RAM_DEPTH; i++) begin
            shadow[i] = 8'h00;
        end
        $readmemh(RAM_INIT_FILE, shadow);
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (8) fetchWord(imageAddr());
        repeat (10) storeThenLoad();
        repeat (4) raceDataFetch();

        // same mix again under stall bursts
        stallOn = 1'b1;
        repeat (8) fetchWord(imageAddr());
        repeat (8) storeThenLoad();
        repeat (4) raceDataFetch();
        stallOn = 1'b0;
        repeat (4) @(posedge clk);

        propErrors = dut0.ctrl0.props0.failCount;
        $display("errors: %0d value, %0d handshake, %0d property",
                 valueErrors, otherErrors, propErrors);
        if (valueErrors == 0 && otherErrors == 0 && propErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/memCtrlProperties.sv */
`default_nettype none

module memCtrlProperties
    import memPkg::*;
(
    input wire             clk,
    input wire             rst,
    input wire             stall,
    input wire ctrlState_e state,
    input wire             dataEn,
    input wire dataReq_t   dataReq,
    input wire             fetchDone,
    input wire             dataDone,
    input wire memPort_t   memCmd
);

    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;

    // age of a load that has run without a stall so far
    logic loadClean;
    stage_t loadAge;
    len_t loadLen;

    always_ff @(posedge clk) begin
        if (rst) begin
            loadClean <= 1'b0;
            loadAge   <= '0;
        end else if (state == IDLE && !stall && dataEn && !dataReq.write) begin
            loadClean <= 1'b1;
            loadAge   <= '0;
            loadLen   <= dataReq.len;
        end else if (loadClean) begin
            if (stall || dataDone) begin
                loadClean <= 1'b0;
            end
            loadAge <= loadAge + 3'd1;
        end
    end

    aResetQuiet: assert property (@(posedge clk)
        rst |=> state == IDLE && !fetchDone && !dataDone && !memCmd.write)
        else begin
            failCount++;
            $error("controller not idle and quiet after reset");
        end

    aIdleQuiet: assert property (@(posedge clk) disable iff (rst)
        state == IDLE |-> !fetchDone && !dataDone && !memCmd.write)
        else begin
            failCount++;
            $error("done or ram write while idle");
        end

    aStallQuiet: assert property (@(posedge clk) disable iff (rst)
        stall |-> !fetchDone && !dataDone && !memCmd.write)
        else begin
            failCount++;
            $error("done or ram write in a stalled cycle");
        end

    aFetchPulse: assert property (@(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone)
        else begin
            failCount++;
            $error("fetchDone longer than one cycle");
        end

    aDataPulse: assert property (@(posedge clk) disable iff (rst)
        dataDone |=> !dataDone)
        else begin
            failCount++;
            $error("dataDone longer than one cycle");
        end

    // done exactly len cycles after acceptance and never earlier
    aLoadLatency: assert property (@(posedge clk) disable iff (rst)
        loadClean && !stall |-> dataDone == (loadAge == loadLen))
        else begin
            failCount++;
            $error("stall-free load done at the wrong cycle");
        end

endmodule

bind memCtrl memCtrlProperties props0 (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .state     (state),
    .dataEn    (dataEn),
    .dataReq   (dataReq),
    .fetchDone (fetchDone),
    .dataDone  (dataDone),
    .memCmd    (memCmd)
);

`default_nettype wire

/* source/memSubsystem.sv */
`default_nettype none

module memSubsystem
    import memPkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire           rdy,
    input  wire           ioBufferFull,

    input  wire           fetchEn,
    input  wire addr_t    fetchAddr,
    output logic          fetchDone,
    output word_t         fetchInst,

    input  wire           dataEn,
    input  wire dataReq_t dataReq,
    output logic          dataDone,
    output word_t         dataRdata
);

    // internal ram port
    memPort_t memCmd;
    byte_t memRdata;

    memCtrl ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .fetchDone    (fetchDone),
        .fetchInst    (fetchInst),
        .dataEn       (dataEn),
        .dataReq      (dataReq),
        .dataDone     (dataDone),
        .dataRdata    (dataRdata),
        .memCmd       (memCmd),
        .memRdata     (memRdata)
    );

    byteRam ram0 (
        .clk      (clk),
        .memCmd   (memCmd),
        .memRdata (memRdata)
    );

endmodule

`default_nettype wire

/* source/memCtrl.sv */
`default_nettype none

module memCtrl
    import memPkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        rdy,
    input  wire        ioBufferFull,

    // instruction fetch side
    input  wire        fetchEn,
    input  wire addr_t fetchAddr,
    output logic       fetchDone,
    output word_t      fetchInst,

    // load/store side
    input  wire          dataEn,
    input  wire dataReq_t dataReq,
    output logic         dataDone,
    output word_t        dataRdata,

    // byte-wide ram port
    output memPort_t   memCmd,
    input  wire byte_t memRdata
);

    ctrlState_e state;
    stage_t stage;
    stage_t endStage;
    stage_t rdStage;

    // latched request
    addr_t baseAddr;
    len_t len;

    // load bytes shift in at the top and store bytes shift out at the bottom
    word_t wordBuf;
    word_t fullWord;
    word_t loadWord;

    logic stall;
    logic doneCycle;

    assign stall = !rdy || ioBufferFull;

    // stores finish one stage earlier as nothing comes back from the ram
    always_comb begin
        if (state == STORE) begin
            endStage = len - 3'd1;
        end else begin
            endStage = len;
        end
    end

    assign doneCycle = (state != IDLE) && (stage == endStage) && !stall;

    // state and stage counter
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            stage <= '0;
        end else if (!stall) begin
            case (state)
                IDLE: begin
                    stage <= '0;
                    // data side wins over a pending fetch
                    if (dataEn) begin
                        state <= dataReq.write ? STORE : LOAD;
                    end else if (fetchEn) begin
                        state <= FETCH;
                    end
                end
                default: begin
                    if (stage == endStage) begin
                        state <= IDLE;
                        stage <= '0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
            endcase
        end
    end

    // request latch and byte shifter
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == IDLE) begin
                if (dataEn) begin
                    baseAddr <= dataReq.addr;
                    len      <= dataReq.len;
                    wordBuf  <= dataReq.storeData;
                end else if (fetchEn) begin
                    baseAddr <= fetchAddr;
                    len      <= FETCH_LEN;
                end
            end else if (state == STORE || stage != 3'd0) begin
                // stage 0 of a read has no byte back yet
                wordBuf <= {memRdata, wordBuf[31:8]};
            end
        end
    end

    // A stalled cycle points the ram one byte back so that the byte the
    // current stage expects is still on memRdata when the stall ends.
    always_comb begin
        if (stall) begin
            rdStage = stage - 3'd1;
        end else begin
            rdStage = stage;
        end
    end

    always_comb begin
        memCmd.write = (state == STORE) && !stall;
        memCmd.addr  = baseAddr + addr_t'(rdStage);
        memCmd.wdata = wordBuf[7:0];
    end

    // top byte comes straight from the ram in the done cycle
    assign fullWord = {memRdata, wordBuf[31:8]};

    // zero extension of short loads
    always_comb begin
        case (len)
            3'd1:    loadWord = {24'h00_0000, fullWord[31:24]};
            3'd2:    loadWord = {16'h0000, fullWord[31:16]};
            default: loadWord = fullWord;
        endcase
    end

    always_comb begin
        fetchDone = doneCycle && (state == FETCH);
        dataDone  = doneCycle && (state == LOAD || state == STORE);
        fetchInst = fullWord;
        dataRdata = loadWord;
    end

endmodule

`default_nettype wire

/* source/byteRam.sv */
`default_nettype none

module byteRam
    import memPkg::*;
(
    input  wire           clk,
    input  wire memPort_t memCmd,
    output byte_t         memRdata
);

    byte_t mem [0:RAM_DEPTH-1];

    // upper address bits are ignored so the ram wraps
    logic [RAM_ADDR_W-1:0] ramAddr;

    assign ramAddr = memCmd.addr[RAM_ADDR_W-1:0];

    initial begin
        $readmemh(RAM_INIT_FILE, mem);
    end

    always_ff @(posedge clk) begin
        if (memCmd.write) begin
            mem[ramAddr] <= memCmd.wdata;
        end
    end

    // registered read with one cycle latency
    always_ff @(posedge clk) begin
        memRdata <= mem[ramAddr];
    end

endmodule

`default_nettype wire

/* source/memPkg.sv */
`default_nettype none

package memPkg;

    // processor side
    localparam int ADDR_W = 32;

    // ram geometry of 1 KiB
    localparam int RAM_ADDR_W = 10;
    localparam int RAM_DEPTH = 1 << RAM_ADDR_W;
    localparam string RAM_INIT_FILE = "verif/memInit.hex";

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0] byte_t;

    // access length in bytes where only 1, 2 and 4 are legal
    typedef logic [2:0] len_t;

    // byte counter inside one request
    typedef logic [2:0] stage_t;

    // instruction fetches are always a full word
    localparam len_t FETCH_LEN = 3'd4;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        LOAD,
        STORE
    } ctrlState_e;

    // data side request of 68 bits
    typedef struct packed {
        logic  write;
        len_t  len;
        addr_t addr;
        word_t storeData;
    } dataReq_t;

    // one byte command to the ram of 41 bits
    typedef struct packed {
        logic  write;
        addr_t addr;
        byte_t wdata;
    } memPort_t;

endpackage

`default_nettype wire
